/* hdl/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define REG_COUNT   32
`define RESET_PC    32'h0000_0000

// instruction field widths, msb to lsb
`define OPCODE_W    6
`define SHAMT_W     5
`define FUNCT_W     6
`define IMM_W       16
`define TARGET_W    26

`endif

/* hdl/isaPkg.sv */
`include "core_consts.svh"

package isaPkg;

    typedef enum logic [`OPCODE_W-1:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    typedef enum logic [`FUNCT_W-1:0] {
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_SLT  = 6'd42
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOp_e;

    // one fetched word, three ways to read it
    typedef union packed {
        struct packed {
            opcode_e                opcode;
            logic [`REG_ADDR_W-1:0] rs;
            logic [`REG_ADDR_W-1:0] rt;
            logic [`REG_ADDR_W-1:0] rd;
            logic [`SHAMT_W-1:0]    shamt;
            funct_e                 funct;
        } rView;
        struct packed {
            opcode_e                opcode;
            logic [`REG_ADDR_W-1:0] rs;
            logic [`REG_ADDR_W-1:0] rt;
            logic [`IMM_W-1:0]      imm;
        } iView;
        struct packed {
            opcode_e                opcode;
            logic [`TARGET_W-1:0]   target;
        } jView;
    } instrWord_u;

endpackage

/* hdl/pipePkg.sv */
`include "core_consts.svh"

package pipePkg;
    import isaPkg::*;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memWrite;
        logic   aluSrc;
        logic   regDst;
        aluOp_e aluOp;
    } ctrlBits_s;

    typedef struct packed {
        ctrlBits_s              ctrl;
        logic [`WORD_W-1:0]     rdData1;
        logic [`WORD_W-1:0]     rdData2;
        logic [`WORD_W-1:0]     imm;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
    } idEx_s;

    typedef struct packed {
        logic                   regWrite;
        logic                   memToReg;
        logic                   memWrite;
        logic [`WORD_W-1:0]     aluOut;
        logic [`WORD_W-1:0]     wrData;
        logic [`REG_ADDR_W-1:0] dest;
    } exMem_s;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwdSel_e;

endpackage

/* hdl/hazardIf.sv */
`timescale 1ns/1ps

interface hazardIf import pipePkg::*; ();
    logic    stallF;
    logic    stallD;
    logic    flushD;
    logic    flushE;
    fwdSel_e fwdA;
    fwdSel_e fwdB;
    logic    fwdBrA;
    logic    fwdBrB;
    logic    memHold;

    modport ctrl (output stallF, stallD, flushD, flushE, fwdA, fwdB,
                  output fwdBrA, fwdBrB, memHold);
    modport fetch (input stallF, flushD, memHold);
    modport exec (input flushE, fwdA, fwdB, memHold);
endinterface

/* hdl/regFile.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module regFile (
    input  logic                   CLK,
    input  logic [`REG_ADDR_W-1:0] i_rdAddr1,
    input  logic [`REG_ADDR_W-1:0] i_rdAddr2,
    output logic [`WORD_W-1:0]     o_rdData1,
    output logic [`WORD_W-1:0]     o_rdData2,
    input  logic                   i_wrEn,
    input  logic [`REG_ADDR_W-1:0] i_wrAddr,
    input  logic [`WORD_W-1:0]     i_wrData
);
    logic [`WORD_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge CLK) begin
        if (i_wrEn && (i_wrAddr != '0))
            regs[i_wrAddr] <= i_wrData;
    end

    // same-cycle write is seen by decode
    assign o_rdData1 = (i_rdAddr1 == '0) ? '0 :
                       (i_wrEn && (i_wrAddr == i_rdAddr1)) ? i_wrData : regs[i_rdAddr1];
    assign o_rdData2 = (i_rdAddr2 == '0) ? '0 :
                       (i_wrEn && (i_wrAddr == i_rdAddr2)) ? i_wrData : regs[i_rdAddr2];

endmodule

/* hdl/fetchUnit.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module fetchUnit import isaPkg::*; (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic [`WORD_W-1:0] i_instr,
    input  logic               i_branchTaken,
    input  logic               i_jump,
    input  logic [`WORD_W-1:0] i_immD,
    output logic [`WORD_W-1:0] o_pc,
    output instrWord_u         o_instrD,
    output logic [`WORD_W-1:0] o_pcPlus4D,
    hazardIf.fetch             hz
);
    logic [`WORD_W-1:0] pcPlus4;
    logic [`WORD_W-1:0] branchTarget;
    logic [`WORD_W-1:0] jumpTarget;
    logic [`WORD_W-1:0] pcNext;

    assign pcPlus4 = o_pc + `WORD_W'd4;
    assign branchTarget = o_pcPlus4D + {i_immD[`WORD_W-3:0], 2'b00};
    assign jumpTarget = {o_pcPlus4D[`WORD_W-1:`TARGET_W+2], o_instrD.jView.target, 2'b00};

    always_comb begin
        if (i_jump)
            pcNext = jumpTarget;
        else if (i_branchTaken)
            pcNext = branchTarget;
        else
            pcNext = pcPlus4;
    end

    always_ff @(posedge CLK) begin
        if (!rst_n)
            o_pc <= `RESET_PC;
        else if (!hz.memHold && !hz.stallF)
            o_pc <= pcNext;
    end

    // fetch/decode register, zero word decodes as a bubble
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            o_instrD <= '0;
            o_pcPlus4D <= '0;
        end else if (!hz.memHold) begin
            if (hz.flushD) begin
                o_instrD <= '0;
                o_pcPlus4D <= '0;
            end else if (!hz.stallF) begin
                o_instrD <= i_instr;
                o_pcPlus4D <= pcPlus4;
            end
        end
    end

    pcAligned: assert property (@(posedge CLK) disable iff (!rst_n) o_pc[1:0] == 2'b00);

endmodule

/* hdl/pipeControl.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module pipeControl import isaPkg::*, pipePkg::*; (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  instrWord_u             i_instrD,
    input  logic [`WORD_W-1:0]     i_rdData1,
    input  logic [`WORD_W-1:0]     i_rdData2,
    input  logic [`WORD_W-1:0]     i_aluOutM,
    input  logic [`REG_ADDR_W-1:0] i_destE,
    input  logic [`REG_ADDR_W-1:0] i_destM,
    input  logic [`REG_ADDR_W-1:0] i_destW,
    input  logic                   i_regWriteE,
    input  logic                   i_regWriteM,
    input  logic                   i_regWriteW,
    input  logic                   i_memToRegE,
    input  logic                   i_memToRegM,
    input  logic                   i_busWait,
    output ctrlBits_s              o_ctrlD,
    output logic [`WORD_W-1:0]     o_immD,
    output logic                   o_branchTaken,
    output logic                   o_jump,
    hazardIf.ctrl                  hz
);
    opcode_e                opD;
    logic [`REG_ADDR_W-1:0] rsD;
    logic [`REG_ADDR_W-1:0] rtD;
    logic [`REG_ADDR_W-1:0] rsE;
    logic [`REG_ADDR_W-1:0] rtE;
    logic                   isBranch;
    logic                   usesRs;
    logic                   usesRt;
    logic                   lwStall;
    logic                   brStall;
    logic [`WORD_W-1:0]     cmpA;
    logic [`WORD_W-1:0]     cmpB;
    logic                   opEqual;

    assign opD = i_instrD.iView.opcode;
    assign rsD = i_instrD.iView.rs;
    assign rtD = i_instrD.iView.rt;
    assign isBranch = (opD == OP_BEQ) || (opD == OP_BNE);
    // j has target bits where rs would be
    assign usesRs = (opD != OP_J);
    assign usesRt = (opD == OP_RTYPE) || (opD == OP_SW) || isBranch;
    assign o_jump = (opD == OP_J);
    assign o_immD = {{(`WORD_W-`IMM_W){i_instrD.iView.imm[`IMM_W-1]}}, i_instrD.iView.imm};

    always_comb begin
        o_ctrlD = '0;
        o_ctrlD.aluOp = ALU_ADD;
        case (opD)
            OP_RTYPE: begin
                o_ctrlD.regDst = 1'b1;
                o_ctrlD.regWrite = 1'b1;
                case (i_instrD.rView.funct)
                    FN_ADDU: o_ctrlD.aluOp = ALU_ADD;
                    FN_SUBU: o_ctrlD.aluOp = ALU_SUB;
                    FN_AND:  o_ctrlD.aluOp = ALU_AND;
                    FN_OR:   o_ctrlD.aluOp = ALU_OR;
                    FN_SLT:  o_ctrlD.aluOp = ALU_SLT;
                    // unknown function acts as a nop
                    default: o_ctrlD.regWrite = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                o_ctrlD.regWrite = 1'b1;
                o_ctrlD.aluSrc = 1'b1;
            end
            OP_LW: begin
                o_ctrlD.regWrite = 1'b1;
                o_ctrlD.memToReg = 1'b1;
                o_ctrlD.aluSrc = 1'b1;
            end
            OP_SW: begin
                o_ctrlD.memWrite = 1'b1;
                o_ctrlD.aluSrc = 1'b1;
            end
            default: ;
        endcase
    end

    // load result not ready for the next instruction
    assign lwStall = i_memToRegE && (i_destE != '0) &&
                     ((usesRs && (i_destE == rsD)) || (usesRt && (i_destE == rtD)));

    // branch operands still in execute, or a load in memory
    assign brStall = isBranch && (
        (i_regWriteE && (i_destE != '0) && ((i_destE == rsD) || (i_destE == rtD))) ||
        (i_memToRegM && (i_destM != '0) && ((i_destM == rsD) || (i_destM == rtD))));

    assign hz.fwdBrA = i_regWriteM && (i_destM != '0) && (i_destM == rsD);
    assign hz.fwdBrB = i_regWriteM && (i_destM != '0) && (i_destM == rtD);
    assign cmpA = hz.fwdBrA ? i_aluOutM : i_rdData1;
    assign cmpB = hz.fwdBrB ? i_aluOutM : i_rdData2;
    assign opEqual = (cmpA == cmpB);

    assign o_branchTaken = !brStall &&
        (((opD == OP_BEQ) && opEqual) || ((opD == OP_BNE) && !opEqual));

    assign hz.stallF = lwStall || brStall;
    assign hz.stallD = lwStall || brStall;
    assign hz.flushE = lwStall || brStall;
    assign hz.flushD = o_branchTaken || o_jump;
    assign hz.memHold = i_busWait;

    // source registers follow the decode/execute register
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            rsE <= '0;
            rtE <= '0;
        end else if (!i_busWait) begin
            rsE <= hz.flushE ? '0 : rsD;
            rtE <= hz.flushE ? '0 : rtD;
        end
    end

    always_comb begin
        hz.fwdA = FWD_REG;
        if (i_regWriteM && (i_destM != '0) && (i_destM == rsE))
            hz.fwdA = FWD_MEM;
        else if (i_regWriteW && (i_destW != '0) && (i_destW == rsE))
            hz.fwdA = FWD_WB;
    end

    always_comb begin
        hz.fwdB = FWD_REG;
        if (i_regWriteM && (i_destM != '0) && (i_destM == rtE))
            hz.fwdB = FWD_MEM;
        else if (i_regWriteW && (i_destW != '0) && (i_destW == rtE))
            hz.fwdB = FWD_WB;
    end

    stallFlushExcl: assert property (@(posedge CLK) disable iff (!rst_n)
        !(hz.stallD && hz.flushD));

endmodule

/* hdl/executeUnit.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module executeUnit import isaPkg::*, pipePkg::*; (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  idEx_s                  i_idEx,
    input  logic [`WORD_W-1:0]     i_resultW,
    output exMem_s                 o_exMem,
    output logic [`REG_ADDR_W-1:0] o_destE,
    output logic                   o_regWriteE,
    output logic                   o_memToRegE,
    hazardIf.exec                  hz
);
    idEx_s              idExQ;
    logic [`WORD_W-1:0] srcA;
    logic [`WORD_W-1:0] fwdB;
    logic [`WORD_W-1:0] srcB;
    logic [`WORD_W-1:0] aluOut;

    always_ff @(posedge CLK) begin
        if (!rst_n)
            idExQ <= '0;
        else if (!hz.memHold)
            idExQ <= hz.flushE ? '0 : i_idEx;
    end

    always_comb begin
        case (hz.fwdA)
            FWD_WB:  srcA = i_resultW;
            FWD_MEM: srcA = o_exMem.aluOut;
            default: srcA = idExQ.rdData1;
        endcase
        case (hz.fwdB)
            FWD_WB:  fwdB = i_resultW;
            FWD_MEM: fwdB = o_exMem.aluOut;
            default: fwdB = idExQ.rdData2;
        endcase
    end

    assign srcB = idExQ.ctrl.aluSrc ? idExQ.imm : fwdB;

    always_comb begin
        case (idExQ.ctrl.aluOp)
            ALU_SUB: aluOut = srcA - srcB;
            ALU_AND: aluOut = srcA & srcB;
            ALU_OR:  aluOut = srcA | srcB;
            ALU_SLT: aluOut = {{(`WORD_W-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default: aluOut = srcA + srcB;
        endcase
    end

    assign o_destE = idExQ.ctrl.regDst ? idExQ.rd : idExQ.rt;
    assign o_regWriteE = idExQ.ctrl.regWrite;
    assign o_memToRegE = idExQ.ctrl.memToReg;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            o_exMem <= '0;
        end else if (!hz.memHold) begin
            o_exMem.regWrite <= idExQ.ctrl.regWrite;
            o_exMem.memToReg <= idExQ.ctrl.memToReg;
            o_exMem.memWrite <= idExQ.ctrl.memWrite;
            o_exMem.aluOut <= aluOut;
            o_exMem.wrData <= fwdB;
            o_exMem.dest <= o_destE;
        end
    end

endmodule

/* hdl/memWriteback.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module memWriteback import pipePkg::*; (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  exMem_s                 i_exMem,
    input  logic [`WORD_W-1:0]     i_memRdData,
    input  logic                   i_memReady,
    output logic [`WORD_W-1:0]     o_memAddr,
    output logic [`WORD_W-1:0]     o_memWrData,
    output logic                   o_memWrite,
    output logic                   o_memRead,
    output logic                   o_busWait,
    output logic                   o_wbEn,
    output logic [`REG_ADDR_W-1:0] o_wbAddr,
    output logic [`WORD_W-1:0]     o_wbData
);
    logic               memToRegW;
    logic [`WORD_W-1:0] aluOutW;
    logic [`WORD_W-1:0] rdDataW;

    // request comes straight from the memory-stage register
    assign o_memAddr = i_exMem.aluOut;
    assign o_memWrData = i_exMem.wrData;
    assign o_memWrite = i_exMem.memWrite;
    assign o_memRead = i_exMem.memToReg;
    assign o_busWait = (o_memWrite || o_memRead) && !i_memReady;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            o_wbEn <= 1'b0;
            memToRegW <= 1'b0;
        end else if (!o_busWait) begin
            o_wbEn <= i_exMem.regWrite;
            memToRegW <= i_exMem.memToReg;
        end
    end

    always_ff @(posedge CLK) begin
        if (!o_busWait) begin
            o_wbAddr <= i_exMem.dest;
            aluOutW <= i_exMem.aluOut;
            rdDataW <= i_memRdData;
        end
    end

    assign o_wbData = memToRegW ? rdDataW : aluOutW;

    rdWrExcl: assert property (@(posedge CLK) disable iff (!rst_n) !(o_memWrite && o_memRead));

endmodule

/* hdl/mipsCore.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module mipsCore import isaPkg::*; (
    input  logic               CLK,
    input  logic               rst_n,
    output logic [`WORD_W-1:0] o_pc,
    input  logic [`WORD_W-1:0] i_instr,
    output logic [`WORD_W-1:0] o_memAddr,
    output logic [`WORD_W-1:0] o_memWrData,
    output logic               o_memWrite,
    output logic               o_memRead,
    input  logic [`WORD_W-1:0] i_memRdData,
    input  logic               i_memReady
);
    instrWord_u             instrD;
    logic [`WORD_W-1:0]     immD;
    logic [`WORD_W-1:0]     rdData1;
    logic [`WORD_W-1:0]     rdData2;
    logic [`WORD_W-1:0]     wbData;
    logic [`REG_ADDR_W-1:0] wbAddr;
    logic [`REG_ADDR_W-1:0] destE;
    logic                   wbEn;
    logic                   regWriteE;
    logic                   memToRegE;
    logic                   branchTaken;
    logic                   jump;
    logic                   busWait;
    pipePkg::ctrlBits_s     ctrlD;
    pipePkg::idEx_s         idExD;
    pipePkg::exMem_s        exMem;

    hazardIf hz ();

    assign idExD = '{ctrl: ctrlD, rdData1: rdData1, rdData2: rdData2, imm: immD,
                     rs: instrD.rView.rs, rt: instrD.rView.rt, rd: instrD.rView.rd};

    pipeControl u_pipeControl (
        .CLK(CLK), .rst_n(rst_n), .i_instrD(instrD),
        .i_rdData1(rdData1), .i_rdData2(rdData2), .i_aluOutM(exMem.aluOut),
        .i_destE(destE), .i_destM(exMem.dest), .i_destW(wbAddr),
        .i_regWriteE(regWriteE), .i_regWriteM(exMem.regWrite), .i_regWriteW(wbEn),
        .i_memToRegE(memToRegE), .i_memToRegM(exMem.memToReg), .i_busWait(busWait),
        .o_ctrlD(ctrlD), .o_immD(immD), .o_branchTaken(branchTaken), .o_jump(jump),
        .hz(hz.ctrl)
    );

    fetchUnit u_fetchUnit (
        .CLK(CLK), .rst_n(rst_n), .i_instr(i_instr), .i_branchTaken(branchTaken),
        .i_jump(jump), .i_immD(immD), .o_pc(o_pc), .o_instrD(instrD),
        .o_pcPlus4D(), .hz(hz.fetch)
    );

    regFile u_regFile (
        .CLK(CLK), .i_rdAddr1(instrD.rView.rs), .i_rdAddr2(instrD.rView.rt),
        .o_rdData1(rdData1), .o_rdData2(rdData2),
        .i_wrEn(wbEn), .i_wrAddr(wbAddr), .i_wrData(wbData)
    );

    executeUnit u_executeUnit (
        .CLK(CLK), .rst_n(rst_n), .i_idEx(idExD), .i_resultW(wbData), .o_exMem(exMem),
        .o_destE(destE), .o_regWriteE(regWriteE), .o_memToRegE(memToRegE), .hz(hz.exec)
    );

    memWriteback u_memWriteback (
        .CLK(CLK), .rst_n(rst_n), .i_exMem(exMem), .i_memRdData(i_memRdData),
        .i_memReady(i_memReady), .o_memAddr(o_memAddr), .o_memWrData(o_memWrData),
        .o_memWrite(o_memWrite), .o_memRead(o_memRead), .o_busWait(busWait),
        .o_wbEn(wbEn), .o_wbAddr(wbAddr), .o_wbData(wbData)
    );

endmodule

/* bench/tbMipsCore.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module tbMipsCore;
    localparam string       DATA_FILE = "bench/core_testdata.txt";
    localparam int          MEM_WORDS = 256;
    localparam int          DRAIN_CYCLES = 16;
    localparam logic [31:0] LFSR_SEED = 32'h9af0b878;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic               CLK;
    logic               rst_n;
    logic [`WORD_W-1:0] pc;
    logic [`WORD_W-1:0] instr;
    logic [`WORD_W-1:0] memAddr;
    logic [`WORD_W-1:0] memWrData;
    logic               memWrite;
    logic               memRead;
    logic [`WORD_W-1:0] memRdData;
    logic               memReady;

    logic [`WORD_W-1:0] romWords [$];
    logic [`WORD_W-1:0] dataMem [MEM_WORDS];
    logic [`WORD_W-1:0] expAddr [$];
    logic [`WORD_W-1:0] expData [$];
    int                 expTest [$];
    logic [31:0]        lfsrState;
    int                 cycleCount = 0;
    int                 cycleLimit = 0;
    int                 storeIdx = 0;
    int                 errorCount = 0;
    int                 testStores = 0;
    int                 testErrors = 0;
    bit                 loaded = 1'b0;

    mipsCore i_mipsCore (
        .CLK(CLK), .rst_n(rst_n), .o_pc(pc), .i_instr(instr), .o_memAddr(memAddr),
        .o_memWrData(memWrData), .o_memWrite(memWrite), .o_memRead(memRead),
        .i_memRdData(memRdData), .i_memReady(memReady)
    );

    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ LFSR_TAPS;
        return state >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic takeBit(output logic bitOut);
        bitOut = lfsrState[0];
        lfsrState = stepLfsr(lfsrState);
    endtask

    task automatic fillDataMem();
        logic [`WORD_W-1:0] addr;
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr = i * 4;
            dataMem[i] = {~addr[15:0], addr[15:0]};
        end
    endtask

    task automatic loadTestData();
        int                 fd;
        int                 count;
        int                 testId;
        string              line;
        byte                tag;
        logic [`WORD_W-1:0] valA;
        logic [`WORD_W-1:0] valB;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s", DATA_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            count = $fgets(line, fd);
            if (count > 1) begin
                tag = line.getc(0);
                count = $sscanf(line.substr(1, line.len() - 1), "%h %h %d", valA, valB, testId);
                case (tag)
                    "P": romWords.push_back(valA);
                    "D": dataMem[valA[9:2]] = valB;
                    "S": begin
                        expAddr.push_back(valA);
                        expData.push_back(valB);
                        expTest.push_back(testId);
                    end
                    default: ;
                endcase
            end
        end
        $fclose(fd);
    endtask

    task automatic checkStore();
        dataMem[memAddr[9:2]] = memWrData;
        if (storeIdx >= expAddr.size()) begin
            $display("unexpected store of %h to %h after the last expected store",
                     memWrData, memAddr);
            errorCount++;
            return;
        end
        if (memAddr !== expAddr[storeIdx]) begin
            $display("mismatch o_memAddr at store %0d: got %h, expected %h",
                     storeIdx, memAddr, expAddr[storeIdx]);
            errorCount++;
            testErrors++;
        end
        if (memWrData !== expData[storeIdx]) begin
            $display("mismatch o_memWrData at store %0d: got %h, expected %h",
                     storeIdx, memWrData, expData[storeIdx]);
            errorCount++;
            testErrors++;
        end
        testStores++;
        storeIdx++;
        // a test ends with its last listed store
        if (storeIdx == expAddr.size() || expTest[storeIdx] != expTest[storeIdx - 1]) begin
            $display("test %0d finished: %0d stores, %0d errors",
                     expTest[storeIdx - 1], testStores, testErrors);
            testStores = 0;
            testErrors = 0;
        end
    endtask

    task automatic finishRun();
        $display("%0d of %0d stores checked, %0d errors", storeIdx, expAddr.size(), errorCount);
        if (errorCount == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    initial begin : clockGen
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK)
        cycleCount <= cycleCount + 1;

    // rom, data memory and random ready, driven 1 ns after the rising edge
    initial begin : busModel
        int   resetEdges;
        int   romIdx;
        logic readyLow0;
        logic readyLow1;
        rst_n = 1'b0;
        instr = '0;
        memRdData = '0;
        memReady = 1'b0;
        lfsrState = LFSR_SEED;
        resetEdges = 0;
        fillDataMem();
        loadTestData();
        cycleLimit = romWords.size() * 8 + 50;
        loaded = 1'b1;
        forever begin
            @(posedge CLK);
            #1;
            resetEdges++;
            if (resetEdges >= 2)
                rst_n = 1'b1;
            romIdx = pc >> 2;
            instr = (romIdx < romWords.size()) ? romWords[romIdx] : '0;
            takeBit(readyLow0);
            takeBit(readyLow1);
            memReady = !(readyLow0 && readyLow1);
            // read data only valid for a read that completes this cycle
            if (memRead && memReady)
                memRdData = dataMem[memAddr[9:2]];
            else
                memRdData = ~dataMem[memAddr[9:2]];
            // bus outputs are settled mid-cycle
            @(negedge CLK);
            if (rst_n && memReady && (memWrite || memRead) && (memAddr >= MEM_WORDS * 4)) begin
                $display("bus access to address %h outside the data memory", memAddr);
                errorCount++;
            end else if (rst_n && memWrite && memReady) begin
                checkStore();
            end
        end
    end

    initial begin : sequencer
        while (!loaded)
            @(posedge CLK);
        if (romWords.size() == 0 || expAddr.size() == 0) begin
            $display("no program or no expected stores found in %s", DATA_FILE);
            errorCount++;
        end else begin
            while (storeIdx < expAddr.size())
                @(posedge CLK);
            // extra stores still show up in the monitor
            repeat (DRAIN_CYCLES) @(posedge CLK);
        end
        finishRun();
    end

    initial begin : watchdog
        while (!loaded)
            @(posedge CLK);
        while (cycleCount < cycleLimit)
            @(posedge CLK);
        $display("timeout after %0d cycles with %0d of %0d stores seen",
                 cycleCount, storeIdx, expAddr.size());
        errorCount++;
        finishRun();
    end

endmodule

/* bench/core_testdata.txt */
# P <instr word>   D <addr> <data>   S <addr> <data> <test id>
# S lines list the expected data-bus writes in order, grouped by test id
D 00000100 11110000
D 00000104 00002222
D 00000108 cafef00d
P 24010007  # addiu $1, $0, 7
P 2402fffd  # addiu $2, $0, -3
P 00221821  # addu  $3, $1, $2
P 00222023  # subu  $4, $1, $2
P 00222824  # and   $5, $1, $2
P 00223025  # or    $6, $1, $2
P 0041382a  # slt   $7, $2, $1
P ac030200  # sw    $3, 0x200($0)
P ac040204  # sw    $4, 0x204($0)
P ac050208  # sw    $5, 0x208($0)
P ac06020c  # sw    $6, 0x20c($0)
P ac070210  # sw    $7, 0x210($0)
P 24280005  # addiu $8, $1, 5
P 01084821  # addu  $9, $8, $8
P 01214823  # subu  $9, $9, $1
P ac090214  # sw    $9, 0x214($0)
P 01095821  # addu  $11, $8, $9
P ac0b0218  # sw    $11, 0x218($0)
P 8c0c0100  # lw    $12, 0x100($0)
P 8c0d0104  # lw    $13, 0x104($0)
P 018d7021  # addu  $14, $12, $13
P ac0e021c  # sw    $14, 0x21c($0)
P 8c0f0108  # lw    $15, 0x108($0)
P ac0f0220  # sw    $15, 0x220($0)
P 24100003  # addiu $16, $0, 3
P 12010001  # beq   $16, $1, +1 (not taken)
P ac100224  # sw    $16, 0x224($0)
P 16010001  # bne   $16, $1, +1 (taken)
P ac0103f0  # sw    $1, 0x3f0($0) skipped
P 26110004  # addiu $17, $16, 4
P 12210001  # beq   $17, $1, +1 (taken)
P ac0003f4  # sw    $0, 0x3f4($0) skipped
P 08000022  # j     0x88
P ac0003f8  # sw    $0, 0x3f8($0) skipped
P ac110228  # sw    $17, 0x228($0)
P 24000055  # addiu $0, $0, 0x55
P ac00022c  # sw    $0, 0x22c($0)
P 8c120200  # lw    $18, 0x200($0)
P 02519821  # addu  $19, $18, $17
P ac130230  # sw    $19, 0x230($0)
P 08000028  # j     0xa0 (spin)
S 00000200 00000004 1
S 00000204 0000000a 1
S 00000208 00000005 1
S 0000020c ffffffff 1
S 00000210 00000001 1
S 00000214 00000011 2
S 00000218 0000001d 2
S 0000021c 11112222 3
S 00000220 cafef00d 3
S 00000224 00000003 4
S 00000228 00000007 4
S 0000022c 00000000 5
S 00000230 0000000b 5

/* src.f */
+incdir+hdl
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/hazardIf.sv
hdl/regFile.sv
hdl/fetchUnit.sv
hdl/pipeControl.sv
hdl/executeUnit.sv
hdl/memWriteback.sv
hdl/mipsCore.sv
bench/tbMipsCore.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbMipsCore
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES) hdl/core_consts.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
